// ==== tb/stream_tests.txt ====
# c <n> <cmd words in hex> | e <four expected words in hex> | w wait for queued packets
# r <0 ready high, 1 random ready> | x reset for two cycles
r 0
e 00000010 00000020 00000030 00000040
c 5 40000010 45000020 42000030 47000040 800000ff
w
e 00000100 00000000 00000000 00000000
c 4 40000100 44000200 41000005 80000001
w
e 00000200 00000005 00000000 00000000
c 1 80000012
w
r 1
e 00000000 00000000 00000bcd 00000007
c 4 42000abc 46000111 43000007 800000ff
w
e 00000000 00000000 00000000 00000000
c 1 800000ff
w
c 2 40000055 45000066
x
e 00000000 00000009 00000000 00000000
c 2 41000009 800000ff
w
r 0
e 00001000 00000023 00000000 00000000
c 5 40001000 45000020 41000003 80000001 80000022
w

// ==== src.f ====
design/stream_pkg.sv
design/agu.sv
design/core_array.sv
design/result_bank.sv
design/stream_ctrl.sv
design/stream_top.sv
tb/stream_checker.sv
tb/stream_top_sva.sv
tb/tb_stream_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_top -f src.f

# the grep below decides pass or fail
out=$(./obj_dir/Vtb_stream_top +verilator+error+limit+1000 2>&1) || true
echo "$out"
echo "$out" | grep -qx "=== PASS ==="

// ==== tb/tb_stream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stream_top;

    import stream_pkg::*;

    localparam int CORENUM = 8;

    // ========================================
    // DUT signals and run state
    // ========================================

    logic       clk = 1'b0;
    logic       rst;
    logic       cmd_valid;
    cmd_word_u  cmd;
    logic       dst_ready;
    wire        dst_valid;
    wire        dst_last;
    wire word_t dst_data;

    // dst_ready held high unless set to draw from $random
    logic       ready_random;
    integer     seed;
    integer     rnd;
    integer     fd;
    int         n_lines;
    int         n_expected;
    int         run_errors;
    int         total;

    // 4 ns period
    always #2 clk = ~clk;

    stream_top #(
        .CORENUM(CORENUM)
    ) i_stream_top (
        .clk      (clk),
        .rst      (rst),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .dst_ready(dst_ready),
        .dst_valid(dst_valid),
        .dst_last (dst_last),
        .dst_data (dst_data)
    );

    // compares output beats with queued packets
    stream_checker i_checker (
        .clk      (clk),
        .rst      (rst),
        .dst_valid(dst_valid),
        .dst_ready(dst_ready),
        .dst_last (dst_last),
        .dst_data (dst_data)
    );

    // protocol assertions inside the top level
    bind stream_top stream_top_sva i_sva (
        .clk      (clk),
        .rst      (rst),
        .dst_ready(dst_ready),
        .dst_valid(dst_valid),
        .dst_last (dst_last),
        .dst_data (dst_data),
        .stream_v (stream_v),
        .stream_i (stream_i)
    );

    // ========================================
    // stimulus tasks
    // ========================================

    // advance to the next falling edge and redraw dst_ready
    task automatic step();
        @(negedge clk);
        rnd       = $random(seed);
        dst_ready = ready_random ? rnd[0] : 1'b1;
    endtask

    // one-cycle strobe so commands land 2 cycles apart
    task automatic send_cmd(input logic [31:0] word);
        step();
        cmd_valid = 1'b1;
        cmd       = word;
        step();
        cmd_valid = 1'b0;
    endtask

    // rst high over two rising edges
    task automatic pulse_reset();
        step();
        rst = 1'b1;
        step();
        step();
        rst = 1'b0;
    endtask

    // until the checker has seen every queued packet
    task automatic wait_packets();
        while (i_checker.packets_done < n_expected) begin
            step();
        end
    endtask

    // ========================================
    // main sequence from the data file
    // ========================================

    initial begin
        logic [8*8-1:0]   kind;
        logic [8*160-1:0] text;
        logic [31:0]      word;
        logic [31:0]      w0;
        logic [31:0]      w1;
        logic [31:0]      w2;
        logic [31:0]      w3;
        int               n;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        dst_ready    = 1'b1;
        ready_random = 1'b0;
        seed         = 32'h6c21_2983;
        n_lines      = 0;
        n_expected   = 0;
        run_errors   = 0;
        fd = $fopen("tb/stream_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/stream_tests.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            // line count sets the watchdog limit
            while ($fgets(text, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            fd = $fopen("tb/stream_tests.txt", "r");
            step();
            step();
            rst = 1'b0;
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    void'($fgets(text, fd));
                end else if (kind == "c") begin
                    void'($fscanf(fd, "%d", n));
                    for (int i = 0; i < n; i++) begin
                        void'($fscanf(fd, "%h", word));
                        send_cmd(word);
                    end
                end else if (kind == "e") begin
                    void'($fscanf(fd, "%h %h %h %h", w0, w1, w2, w3));
                    i_checker.push_packet(w0, w1, w2, w3);
                    n_expected++;
                end else if (kind == "w") begin
                    wait_packets();
                end else if (kind == "r") begin
                    void'($fscanf(fd, "%d", n));
                    ready_random = (n != 0);
                end else if (kind == "x") begin
                    pulse_reset();
                end else begin
                    run_errors++;
                    $display("unknown line kind %0s in test file", kind);
                end
            end
            $fclose(fd);
            // quiet tail where stray beats show up
            repeat (40) step();
            total = i_checker.data_errors + i_checker.last_errors + i_checker.proto_errors
                  + i_stream_top.i_sva.fail_count + run_errors;
            $display("errors: data %0d, last %0d, protocol %0d, assertion %0d, run %0d",
                     i_checker.data_errors, i_checker.last_errors, i_checker.proto_errors,
                     i_stream_top.i_sva.fail_count, run_errors);
            if (total == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

    // watchdog allows 200 cycles per file line plus 100
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200 + 100) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", n_lines * 200 + 100);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/stream_top_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_top_sva (
    input wire                    clk,
    input wire                    rst,
    input wire                    dst_ready,
    input wire                    dst_valid,
    input wire                    dst_last,
    input wire stream_pkg::word_t dst_data,
    input wire                    stream_v,
    input wire [1:0]              stream_i
);

    int fail_count = 0;

    // last only rides on a valid beat
    a_last_valid: assert property (@(posedge clk) disable iff (rst)
        dst_last |-> dst_valid)
    else begin
        fail_count++;
        $error("dst_last high without dst_valid");
    end

    // outputs frozen under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (rst)
        !dst_ready |=> $stable(dst_valid) && $stable(dst_last) && $stable(dst_data))
    else begin
        fail_count++;
        $error("output changed while dst_ready was low");
    end

    // each read steps the index by one
    a_step: assert property (@(posedge clk) disable iff (rst)
        stream_v && (stream_i != 2'd3) |=> stream_i == $past(stream_i) + 2'd1)
    else begin
        fail_count++;
        $error("stream_i skipped a word");
    end

    // index parks on word 3, no wrap
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        stream_v && (stream_i == 2'd3) |=> stream_i == 2'd3)
    else begin
        fail_count++;
        $error("stream_i wrapped within a packet");
    end

endmodule

`default_nettype wire

// ==== tb/stream_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_checker (
    input wire                    clk,
    input wire                    rst,
    input wire                    dst_valid,
    input wire                    dst_ready,
    input wire                    dst_last,
    input wire stream_pkg::word_t dst_data
);

    import stream_pkg::*;

    // ========================================
    // expected packets and counters
    // ========================================

    // word 0 sits in the low slot
    word_t [3:0] exp_q [$];

    int beat         = 0;
    int packets_done = 0;
    int data_errors  = 0;
    int last_errors  = 0;
    int proto_errors = 0;

    // queued by the testbench ahead of the finish
    task automatic push_packet(input word_t w0, input word_t w1, input word_t w2,
                               input word_t w3);
        exp_q.push_back({w3, w2, w1, w0});
    endtask

    // ========================================
    // beat compare
    // ========================================

    // a beat moves at an edge with valid and ready
    always @(posedge clk) begin
        word_t exp_word;
        if (rst) begin
            beat = 0;
        end else if (dst_valid && dst_ready) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("beat with data %h arrived while no packet was expected", dst_data);
            end else begin
                exp_word = exp_q[0][beat];
                if (dst_data !== exp_word) begin
                    data_errors++;
                    $display("Error dst_data: expected %h got %h", exp_word, dst_data);
                end
                // last only on the fourth beat
                if (dst_last !== (beat == 3)) begin
                    last_errors++;
                    $display("Error dst_last: expected %h got %h", beat == 3, dst_last);
                end
                if (beat == 3) begin
                    exp_q.delete(0);
                    packets_done++;
                    beat = 0;
                end else begin
                    beat++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/stream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_top #(
    parameter int CORENUM = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_valid,
    input  wire stream_pkg::cmd_word_u cmd,
    input  wire                        dst_ready,
    output wire                        dst_valid,
    output wire                        dst_last,
    output wire stream_pkg::word_t     dst_data
);

    import stream_pkg::*;

    // ========================================
    // internal wiring
    // ========================================

    // slot sums from a finish
    wire bank_store_t  store;
    // per-lane finish pulses
    wire [CORENUM-1:0] last;
    // bank read strobe and index
    wire               stream_v;
    wire [1:0]         stream_i;

    // lanes, command decode
    core_array #(
        .CORENUM(CORENUM)
    ) i_core_array (
        .clk      (clk),
        .rst      (rst),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .store    (store),
        .last     (last)
    );

    // four result words, read-clear
    result_bank i_result_bank (
        .clk     (clk),
        .rst     (rst),
        .store   (store),
        .stream_v(stream_v),
        .stream_i(stream_i),
        .dst_data(dst_data)
    );

    // packet sequencing, output flags
    stream_ctrl #(
        .CORENUM(CORENUM)
    ) i_stream_ctrl (
        .clk      (clk),
        .rst      (rst),
        .last     (last),
        .dst_ready(dst_ready),
        .dst_valid(dst_valid),
        .dst_last (dst_last),
        .stream_v (stream_v),
        .stream_i (stream_i)
    );

endmodule

`default_nettype wire

// ==== design/stream_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl #(
    parameter int CORENUM = 4
) (
    input  wire               clk,
    input  wire               rst,
    input  wire [CORENUM-1:0] last,
    input  wire               dst_ready,
    output logic              dst_valid,
    output logic              dst_last,
    output logic              stream_v,
    output logic [1:0]        stream_i
);

    // ========================================
    // last event
    // ========================================

    logic last_n;
    logic last_nn;
    logic last_event;
    logic last_keep;
    logic stream_ok;
    logic stream_active;
    logic last_stream;

    // any lane's last, two cycles late
    always_ff @(posedge clk) begin
        if (rst) begin
            last_n  <= 1'b0;
            last_nn <= 1'b0;
        end else begin
            last_n  <= |last;
            last_nn <= last_n;
        end
    end

    // event during a running stream folds into that packet
    assign last_event = last_nn && !stream_active;

    // remember the event while dst_ready is low
    always_ff @(posedge clk) begin
        if (rst) begin
            last_keep <= 1'b0;
        end else if (stream_ok) begin
            // consumed, stream_ok wins over a new event
            last_keep <= 1'b0;
        end else if (last_event) begin
            last_keep <= 1'b1;
        end
    end

    // go when an event is live and the sink can take data
    assign stream_ok = (last_event || last_keep) && dst_ready;

    // ========================================
    // stream sequencing
    // ========================================

    // stays up through all four reads
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (last_stream && dst_ready) begin
            // word 3 read at this edge
            stream_active <= 1'b0;
        end else if (stream_ok) begin
            stream_active <= 1'b1;
        end
    end

    // bank index 0 to 3, stalls with dst_ready
    agu #(
        .W(2)
    ) i_agu (
        .clk  (clk),
        .rst  (rst),
        .start(stream_ok),
        .en   (dst_ready),
        .ini  (2'd0),
        .fin  (2'd3),
        .data (stream_i),
        .last (last_stream)
    );

    // bank read strobe
    assign stream_v = dst_ready && stream_active;

    // ========================================
    // output flags
    // ========================================

    // one cycle behind the read, lined up with dst_data
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
        end
    end

    // marks the beat carrying word 3
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_last <= 1'b0;
        end else if (dst_ready) begin
            dst_last <= stream_active && last_stream;
        end
    end

endmodule

`default_nettype wire

// ==== design/result_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_bank (
    input  wire                          clk,
    input  wire                          rst,
    input  wire stream_pkg::bank_store_t store,
    input  wire                          stream_v,
    input  wire [1:0]                    stream_i,
    output stream_pkg::word_t            dst_data
);

    import stream_pkg::*;

    // ========================================
    // bank words
    // ========================================

    // four result words, one per slot
    word_t bank     [4];
    word_t bank_nxt [4];

    // read clears the word first, a same-cycle store lands on top
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (stream_v && (int'(stream_i) == k)) begin
                bank_nxt[k] = '0;
            end else begin
                bank_nxt[k] = bank[k];
            end
            // stores from several finishes pile up
            if (store.en[k]) begin
                bank_nxt[k] = bank_nxt[k] + store.data[k];
            end
        end
    end

    // bank is zero out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 4; k++) begin
                bank[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                bank[k] <= bank_nxt[k];
            end
        end
    end

    // ========================================
    // output register
    // ========================================

    // moves only on read strobes, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (stream_v) begin
            dst_data <= bank[stream_i];
        end
    end

endmodule

`default_nettype wire

// ==== design/core_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_array #(
    parameter int CORENUM = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cmd_valid,
    input  wire stream_pkg::cmd_word_u   cmd,
    output stream_pkg::bank_store_t      store,
    output logic [CORENUM-1:0]           last
);

    import stream_pkg::*;

    // ========================================
    // command decode
    // ========================================

    logic                 acc_fire;
    logic                 fin_fire;
    word_t                acc_value;
    logic [max_cores-1:0] mask_full;
    logic [CORENUM-1:0]   fin_mask;

    // op field is at the same place in either form
    assign acc_fire  = cmd_valid && (cmd.acc.op == op_acc);
    assign fin_fire  = cmd_valid && (cmd.fin.op == op_fin);
    assign acc_value = {8'd0, cmd.acc.value};
    assign mask_full = cmd.fin.lane_mask;
    // mask bits past the last lane are dropped
    assign fin_mask  = fin_fire ? mask_full[CORENUM-1:0] : '0;

    // ========================================
    // lane accumulators
    // ========================================

    word_t acc [CORENUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < CORENUM; n++) begin
                acc[n] <= '0;
            end
        end else begin
            for (int n = 0; n < CORENUM; n++) begin
                // lane numbers at or above CORENUM match nothing
                if (acc_fire && (int'(cmd.acc.lane) == n)) begin
                    acc[n] <= acc[n] + acc_value;
                end else if (fin_mask[n]) begin
                    // total moves to the bank, lane starts over
                    acc[n] <= '0;
                end
            end
        end
    end

    // ========================================
    // slot sums and bank store
    // ========================================

    word_t [3:0] slot_sum;
    logic  [3:0] slot_hit;

    // lane n folds into slot n mod 4
    always_comb begin
        slot_sum = '0;
        slot_hit = '0;
        for (int n = 0; n < CORENUM; n++) begin
            if (fin_mask[n]) begin
                slot_sum[n % 4] = slot_sum[n % 4] + acc[n];
                slot_hit[n % 4] = 1'b1;
            end
        end
    end

    // store valid one cycle after the finish
    always_ff @(posedge clk) begin
        store.data <= slot_sum;
        if (rst) begin
            store.en <= '0;
        end else begin
            store.en <= slot_hit;
        end
    end

    // last trails store by a cycle so the bank write lands first
    logic [CORENUM-1:0] mask_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mask_q <= '0;
            last   <= '0;
        end else begin
            mask_q <= fin_mask;
            last   <= mask_q;
        end
    end

endmodule

`default_nettype wire

// ==== design/agu.sv ====
`timescale 1ns/1ps
`default_nettype none

module agu #(
    parameter int W = 2
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          start,
    input  wire          en,
    input  wire [W-1:0]  ini,
    input  wire [W-1:0]  fin,
    output logic [W-1:0] data,
    output logic         last
);

    // high from start until the step past fin
    logic running;

    always_ff @(posedge clk) begin
        if (rst) begin
            data    <= '0;
            running <= 1'b0;
        end else if (start) begin
            data    <= ini;
            running <= 1'b1;
        end else if (en && running) begin
            // parks on fin, no wrap back to ini
            if (data == fin) begin
                running <= 1'b0;
            end else begin
                data <= data + 1'b1;
            end
        end
    end

    assign last = running && (data == fin);

endmodule

`default_nettype wire

// ==== design/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

    // ========================================
    // widths
    // ========================================

    // finish mask width, also the upper bound on lane count
    localparam int max_cores = 16;

    // data word for bank entries and output beats
    typedef logic [31:0] word_t;

    // ========================================
    // command word
    // ========================================

    // opcode lives in the top two bits of both forms
    typedef enum logic [1:0] {
        op_nop = 2'd0,
        op_acc = 2'd1,
        op_fin = 2'd2
    } op_e;

    // add value into one lane
    typedef struct packed {
        op_e         op;
        logic [5:0]  lane;
        // unsigned, zero-extended when added
        logic [23:0] value;
    } cmd_acc_t;

    // store and clear a set of lanes
    typedef struct packed {
        op_e                  op;
        logic [13:0]          pad;
        logic [max_cores-1:0] lane_mask;
    } cmd_fin_t;

    // one 32-bit word, two decodings
    typedef union packed {
        cmd_acc_t acc;
        cmd_fin_t fin;
    } cmd_word_u;

    // per-slot write into the result bank
    typedef struct packed {
        logic [3:0]  en;
        word_t [3:0] data;
    } bank_store_t;

endpackage

`default_nettype wire
